// ==== Makefile ====
# Verilator build and run of the board-support testbench

VERILATOR ?= verilator
TOP       ?= tb_board_top
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing

SRCS := $(wildcard hdl/*.sv sim/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) list.f
	$(VERILATOR) $(VFLAGS) -f list.f --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== hdl/board_pkg.sv ====
/* Board-level widths and positions shared by the top level
   and the button debouncer. */

package board_pkg;

	// Samples that must agree before a button level changes
	parameter int deb_depth = 8;

	// Main-board LED row and key pair
	parameter int led_width = 8;
	parameter int key_width = 2;

	// Core LED control is a two-bit mode
	parameter int led_mode_width = 2;

	// Where each front-panel LED shows up on the LED row
	parameter int led_pos_user  = 0;
	parameter int led_pos_disk  = 2;
	parameter int led_pos_power = 4;

	// Configuration word bit for composite sync on the VGA pins
	parameter int cfg_bit_csync = 3;

endpackage

// ==== hdl/board_top.sv ====
/* Board-support top level. Connects the host register pair, buttons,
   front-panel and main-board LEDs and the VGA sync pins. */
`timescale 1ns/10ps

module board_top import host_pkg::*, board_pkg::*; #(
	parameter int div_count = 100000,
	parameter int cnt_width = 20
) (
	input  logic                      FPGA_CLK2_50,
	input  logic                      resetd,
	input  logic [gp_width-1:0]       gp_out,
	output logic [gp_width-1:0]       gp_in,
	input  logic                      btn_user,
	input  logic                      btn_osd,
	input  logic [key_width-1:0]      key,
	input  logic                      core_led_user,
	input  logic [led_mode_width-1:0] core_led_power,
	input  logic [led_mode_width-1:0] core_led_disk,
	input  logic                      core_hs,
	input  logic                      core_vs,
	input  logic                      vga_en,
	output logic                      led_user,
	output logic                      led_hdd,
	output logic                      led_power,
	output logic [led_width-1:0]      led,
	output logic                      vga_hs,
	output logic                      vga_vs,
	output logic [io_data_width-1:0]  cfg,
	output logic                      cfg_ready,
	output logic                      reset_req
);

	logic btn_user_deb;
	logic btn_osd_deb;
	logic hs_norm;
	logic vs_norm;
	logic user_lit;
	logic disk_lit;
	logic power_lit;
	logic csync;

	// ========================================================================
	// Buttons, host I/O and reset
	// ========================================================================

	// User button pairs with key 1, OSD with key 0
	button_debounce #(.div_count(div_count)) deb_user (
		.FPGA_CLK2_50(FPGA_CLK2_50), .resetd(resetd),
		.btn_n(btn_user), .key_n(key[1]), .pressed(btn_user_deb));

	button_debounce #(.div_count(div_count)) deb_osd (
		.FPGA_CLK2_50(FPGA_CLK2_50), .resetd(resetd),
		.btn_n(btn_osd), .key_n(key[0]), .pressed(btn_osd_deb));

	host_io u_host_io (
		.FPGA_CLK2_50(FPGA_CLK2_50), .resetd(resetd), .gp_out(gp_out),
		.btn_user(btn_user_deb), .btn_osd(btn_osd_deb), .gp_in(gp_in),
		.cfg(cfg), .cfg_ready(cfg_ready));

	// Raw code, the latch does its own registering
	reset_request u_reset_request (
		.FPGA_CLK2_50(FPGA_CLK2_50), .resetd(resetd),
		.reset_code(reset_code_e'(gp_out[gp_bit_reset_lo +: 2])),
		.reset_req(reset_req));

	// ========================================================================
	// LEDs
	// ========================================================================

	// Mode high bit set forces the inverted low bit
	assign power_lit = core_led_power[1] ? ~core_led_power[0] : 1'b0;
	assign disk_lit  = core_led_disk[1] ? ~core_led_disk[0]
		: (core_led_disk[0] | gp_out[gp_bit_disk]);
	assign user_lit  = core_led_user;

	// Open drain, pull low to light
	assign led_power = power_lit ? 1'b0 : 1'bz;
	assign led_hdd   = disk_lit ? 1'b0 : 1'bz;
	assign led_user  = user_lit ? 1'b0 : 1'bz;

	always_comb begin
		led                = '0;
		led[led_pos_user]  = user_lit;
		led[led_pos_disk]  = disk_lit;
		led[led_pos_power] = power_lit;
	end

	// ========================================================================
	// VGA sync
	// ========================================================================

	sync_polarity #(.cnt_width(cnt_width)) sync_h (
		.FPGA_CLK2_50(FPGA_CLK2_50), .resetd(resetd),
		.sync_in(core_hs), .sync_out(hs_norm));

	sync_polarity #(.cnt_width(cnt_width)) sync_v (
		.FPGA_CLK2_50(FPGA_CLK2_50), .resetd(resetd),
		.sync_in(core_vs), .sync_out(vs_norm));

	assign csync = cfg[cfg_bit_csync];

	// Pins active low, composite sync rides on hs
	assign vga_vs = vga_en ? 1'bz : (csync ? 1'b1 : ~vs_norm);
	assign vga_hs = vga_en ? 1'bz : (csync ? ~(vs_norm ^ hs_norm) : ~hs_norm);

endmodule

// ==== hdl/button_debounce.sv ====
/* Debouncer for one front-panel button qualified by a main-board key.
   Both inputs are active low, the output is high while pressed. */
`timescale 1ns/10ps

module button_debounce import board_pkg::*; #(
	parameter int div_count = 100000
) (
	input  logic FPGA_CLK2_50,
	input  logic resetd,
	input  logic btn_n,
	input  logic key_n,
	output logic pressed
);

	localparam int div_width = $clog2(div_count + 1);
	localparam logic [div_width-1:0] div_last = div_width'(div_count);

	logic [div_width-1:0] div_cnt;
	logic [deb_depth-1:0] samples;
	logic                 wrap;

	// Sample tick once per divider period
	assign wrap = (div_cnt == div_last);

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			div_cnt <= '0;
		end else if (wrap) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// Shift in the press state, change level only on full agreement
	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			samples <= '0;
			pressed <= 1'b0;
		end else if (wrap) begin
			samples <= {samples[deb_depth-2:0], ~(btn_n & key_n)};
			if (&samples) begin
				pressed <= 1'b1;
			end else if (~|samples) begin
				pressed <= 1'b0;
			end
		end
	end

	// Level only moves on a sample tick
	a_pressed_on_wrap: assert property (@(posedge FPGA_CLK2_50) disable iff (resetd)
		!wrap |=> $stable(pressed));

endmodule

// ==== hdl/host_io.sv ====
/* Host register interface. Resamples the host output word, runs the I/O
   strobe and acknowledge, decodes command transfers and builds the status word. */
`timescale 1ns/10ps

module host_io import host_pkg::*; (
	input  logic                     FPGA_CLK2_50,
	input  logic                     resetd,
	input  logic [gp_width-1:0]      gp_out,
	input  logic                     btn_user,
	input  logic                     btn_osd,
	output logic [gp_width-1:0]      gp_in,
	output logic [io_data_width-1:0] cfg,
	output logic                     cfg_ready
);

	logic [gp_width-1:0]      gp_outd;
	logic [gp_width-1:0]      gp_outr;
	logic [io_data_width-1:0] io_din;
	logic                     io_clk;
	logic                     io_uio;
	logic                     rack;
	logic                     io_ack;
	logic                     io_strobe;
	logic                     old_strobe;
	logic                     has_cmd;
	host_cmd_e                cmd;
	logic [gp_width-1:0]      status;

	// ========================================================================
	// Resampling and strobe
	// ========================================================================

	// Two stages, host register is on another clock
	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			gp_outd <= '0;
			gp_outr <= '0;
		end else begin
			gp_outd <= gp_out;
			gp_outr <= gp_outd;
		end
	end

	assign io_din = gp_outr[io_data_width-1:0];
	assign io_clk = gp_outr[gp_bit_clk];
	assign io_uio = gp_outr[gp_bit_uio];

	// Strobe lasts until the register catches up with the clock bit
	assign io_strobe = io_clk & ~rack;

	// Ack trails rack by one cycle, no wait state any more
	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			rack   <= 1'b0;
			io_ack <= 1'b0;
		end else begin
			rack   <= io_clk;
			io_ack <= rack;
		end
	end

	// ========================================================================
	// Command decoder
	// ========================================================================

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			old_strobe <= 1'b0;
			has_cmd    <= 1'b0;
			cmd        <= cmd_none;
			cfg        <= '0;
			cfg_ready  <= 1'b0;
		end else begin
			old_strobe <= io_strobe;
			if (!io_uio) begin
				// Transfer closed, next word is a command again
				has_cmd <= 1'b0;
			end else if (io_strobe && !old_strobe) begin
				if (!has_cmd) begin
					has_cmd <= 1'b1;
					cmd     <= host_cmd_e'(io_din[7:0]);
				end else if (cmd == cmd_set_cfg) begin
					cfg       <= io_din;
					cfg_ready <= 1'b1;
				end
			end
		end
	end

	// Top bit stays 0 so the host can tell a configured FPGA
	assign status = {1'b0, btn_user, btn_osd, 9'd0, io_ver, 1'b0, io_ack,
		io_data_width'(0)};

	// Magic while the host holds init low
	assign gp_in = gp_out[gp_bit_init] ? status : core_magic;

	// Configuration, once valid, stays valid
	a_cfg_ready_sticky: assert property (@(posedge FPGA_CLK2_50) disable iff (resetd)
		!$past(resetd) && $past(cfg_ready) |-> cfg_ready);

endmodule

// ==== hdl/host_pkg.sv ====
/* Host register layout, interface constants and command encodings.
   Imported by the host I/O logic and the board top level. */

package host_pkg;

	// Host register words
	parameter int gp_width = 32;

	// Bit positions in the host output register
	parameter int gp_bit_init     = 31;
	parameter int gp_bit_reset_lo = 30;
	parameter int gp_bit_disk     = 29;
	parameter int gp_bit_uio      = 20;
	parameter int gp_bit_clk      = 17;

	// Transfer data and interface version
	parameter int io_data_width = 16;
	parameter logic [1:0] io_ver = 2'd1;

	// Host refuses to talk unless it sees this word
	parameter logic [23:0] core_sig  = 24'h5CA623;
	parameter logic [7:0]  core_type = 8'hA4;
	parameter logic [gp_width-1:0] core_magic = {core_sig, core_type};

	// First word of a command transfer
	typedef enum logic [7:0] {
		cmd_none    = 8'd0,
		cmd_set_cfg = 8'd1
	} host_cmd_e;

	// Two-bit reset code from the top of the host register
	typedef enum logic [1:0] {
		rst_idle    = 2'd0,
		rst_assert  = 2'd1,
		rst_release = 2'd2
	} reset_code_e;

endpackage

// ==== hdl/reset_request.sv ====
/* Reset request latch controlled by the host reset code.
   Release only counts when it directly follows the idle code. */
`timescale 1ns/10ps

module reset_request import host_pkg::*; (
	input  logic        FPGA_CLK2_50,
	input  logic        resetd,
	input  reset_code_e reset_code,
	output logic        reset_req
);

	reset_code_e code_d;
	reset_code_e code_dd;
	logic        req_set;
	logic        req_clr;

	// Current and previous code, one cycle apart
	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			code_d  <= rst_idle;
			code_dd <= rst_idle;
		end else begin
			code_d  <= reset_code;
			code_dd <= code_d;
		end
	end

	assign req_set = (code_d == rst_assert);
	// Idle then release, anything else leaves the request alone
	assign req_clr = (code_d == rst_release) && (code_dd == rst_idle);

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			reset_req <= 1'b0;
		end else if (req_set) begin
			reset_req <= 1'b1;
		end else if (req_clr) begin
			reset_req <= 1'b0;
		end
	end

	a_set_clr_exclusive: assert property (@(posedge FPGA_CLK2_50) disable iff (resetd)
		req_set |-> !req_clr);

endmodule

// ==== hdl/sync_polarity.sv ====
/* Sync polarity normaliser. Measures both phases of a periodic sync
   and flips it so the short phase always comes out high. */
`timescale 1ns/10ps

module sync_polarity #(
	parameter int cnt_width = 20
) (
	input  logic FPGA_CLK2_50,
	input  logic resetd,
	input  logic sync_in,
	output logic sync_out
);

	logic                 s1;
	logic                 s2;
	logic [cnt_width-1:0] cnt;
	logic [cnt_width-1:0] high_len;
	logic [cnt_width-1:0] low_len;
	logic                 pol;

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			s1       <= 1'b0;
			s2       <= 1'b0;
			cnt      <= '0;
			high_len <= '0;
			low_len  <= '0;
			pol      <= 1'b0;
		end else begin
			s1 <= sync_in;
			s2 <= s1;
			// Cycles since the last edge, held at full scale
			if (s1 != s2) begin
				cnt <= '0;
			end else if (~&cnt) begin
				cnt <= cnt + 1'b1;
			end
			// Rising edge ends a low phase
			if (s1 && !s2) begin
				low_len <= cnt;
			end
			// Falling edge ends a high phase
			if (!s1 && s2) begin
				high_len <= cnt;
			end
			pol <= (high_len > low_len);
		end
	end

	assign sync_out = sync_in ^ pol;

endmodule

// ==== list.f ====
hdl/host_pkg.sv
hdl/board_pkg.sv
hdl/button_debounce.sv
hdl/host_io.sv
hdl/reset_request.sv
hdl/sync_polarity.sv
hdl/board_top.sv
sim/tb_board_top.sv

// ==== sim/board_stimulus.txt ====
# gp value cycles exp_gp_in mask | check name exp | btn level cycles exp mode(0 wait,1 hold)
# led user pmode dmode hostdisk lit_user lit_disk lit_power led | sync hh hl vh vl en csync
gp 00000000 2 5CA623A4 FFFFFFFF
gp 80000000 5 00040000 FFFFFFFF
gp 80100000 5 00040000 FFFFFFFF
gp 80120001 5 00050000 FFFFFFFF
gp 80100001 5 00040000 FFFFFFFF
gp 80121230 5 00050000 FFFFFFFF
gp 80101230 5 00040000 FFFFFFFF
check cfg 1230
check cfg_ready 1
gp 80001230 5 00040000 FFFFFFFF
gp 80025555 5 00050000 FFFFFFFF
gp 80005555 5 00040000 FFFFFFFF
check cfg 1230
gp 00000000 3 00000000 00000000
check reset_req 0
gp 40000000 2 00000000 00000000
check reset_req 1
gp 00000000 2 00000000 00000000
check reset_req 1
gp 80000000 2 00000000 00000000
check reset_req 0
gp 40000000 2 00000000 00000000
check reset_req 1
gp 80000000 2 00000000 00000000
check reset_req 1
gp 00000000 2 00000000 00000000
gp 80000000 2 00000000 00000000
check reset_req 0
btn 0 150 1 0
btn 1 150 0 0
btn 0 3 0 1
btn 1 80 0 1
led 1 0 0 0 1 0 0 01
led 0 2 0 0 0 0 1 10
led 0 3 0 0 0 0 0 00
led 0 1 0 0 0 0 0 00
led 0 0 1 0 0 1 0 04
led 0 0 0 1 0 1 0 04
led 0 0 2 1 0 1 0 04
led 0 0 3 1 0 0 0 00
led 1 2 0 1 1 1 1 15
gp 80000000 2 00040000 FFFFFFFF
sync 12 4 40 8 0 0
gp 80100000 5 00040000 FFFFFFFF
gp 80120001 5 00050000 FFFFFFFF
gp 80100001 5 00040000 FFFFFFFF
gp 80120008 5 00050000 FFFFFFFF
gp 80100008 5 00040000 FFFFFFFF
gp 80000008 5 00040000 FFFFFFFF
check cfg 0008
sync 12 4 40 8 0 1
sync 12 4 40 8 1 1

// ==== sim/tb_board_top.sv ====
/* Testbench for the board-support top level. Reads ops and expected values
   from the stimulus file and checks host I/O, reset, buttons, LEDs and VGA sync. */
`timescale 1ns/10ps

module tb_board_top import host_pkg::*, board_pkg::*; ();

	logic                     FPGA_CLK2_50;
	logic                     resetd;
	logic [gp_width-1:0]      gp_out;
	wire  [gp_width-1:0]      gp_in;
	logic                     btn_user;
	logic                     btn_osd;
	logic [key_width-1:0]     key;
	logic                     core_led_user;
	logic [1:0]               core_led_power;
	logic [1:0]               core_led_disk;
	logic                     core_hs;
	logic                     core_vs;
	logic                     vga_en;
	wire                      led_user;
	wire                      led_hdd;
	wire                      led_power;
	wire  [led_width-1:0]     led;
	wire                      vga_hs;
	wire                      vga_vs;
	wire  [io_data_width-1:0] cfg;
	wire                      cfg_ready;
	wire                      reset_req;
	int                       errors;
	int                       checks;

	// Board pull-ups, a floating pin reads 1
	pullup (led_user);
	pullup (led_hdd);
	pullup (led_power);
	pullup (vga_hs);
	pullup (vga_vs);

	board_top #(.div_count(6), .cnt_width(12)) uut (
		.FPGA_CLK2_50(FPGA_CLK2_50), .resetd(resetd), .gp_out(gp_out), .gp_in(gp_in),
		.btn_user(btn_user), .btn_osd(btn_osd), .key(key),
		.core_led_user(core_led_user), .core_led_power(core_led_power),
		.core_led_disk(core_led_disk), .core_hs(core_hs), .core_vs(core_vs),
		.vga_en(vga_en), .led_user(led_user), .led_hdd(led_hdd), .led_power(led_power),
		.led(led), .vga_hs(vga_hs), .vga_vs(vga_vs), .cfg(cfg), .cfg_ready(cfg_ready),
		.reset_req(reset_req));

	// 4 ns clock
	always #2 FPGA_CLK2_50 = ~FPGA_CLK2_50;

	// ========================================================================
	// Helpers
	// ========================================================================

	// Inputs change just after the rising edge
	task automatic drive_edge();
		@(posedge FPGA_CLK2_50);
		#0.5;
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("ERR %s got %h expected %h", name, got, exp);
		end
	endtask

	// Host register write, fixed latency from the strobe timing
	// A zero mask only drives the word
	task automatic host_write(input logic [31:0] value, input int cycles,
		input logic [31:0] exp, input logic [31:0] mask);
		drive_edge();
		gp_out = value;
		repeat (cycles) @(posedge FPGA_CLK2_50);
		@(negedge FPGA_CLK2_50);
		if (mask != '0) begin
			check_value("gp_in", gp_in & mask, exp);
		end
	endtask

	task automatic named_check(input string name, input logic [31:0] exp);
		case (name)
			"cfg":       check_value("cfg", 32'(cfg), exp);
			"cfg_ready": check_value("cfg_ready", 32'(cfg_ready), exp);
			"reset_req": check_value("reset_req", 32'(reset_req), exp);
			default: begin
				errors++;
				$display("Unknown signal in a check line: %s", name);
			end
		endcase
	endtask

	// Mode 0 waits for the level with a timeout, mode 1 requires it throughout
	task automatic button_step(input logic level, input int cycles, input logic exp,
		input logic mode);
		int waited;
		drive_edge();
		btn_user = level;
		waited = 0;
		if (!mode) begin
			@(negedge FPGA_CLK2_50);
			while (gp_in[30] !== exp && waited < cycles) begin
				@(negedge FPGA_CLK2_50);
				waited++;
			end
			checks++;
			assert (gp_in[30] === exp) else begin
				errors++;
				$display("Debounced button did not reach %0d before the timeout", exp);
			end
		end else begin
			repeat (cycles) begin
				@(negedge FPGA_CLK2_50);
				check_value("gp_in[30]", 32'(gp_in[30]), 32'(exp));
			end
		end
	endtask

	// Lit pins pull low, unlit pins float high
	task automatic led_case(input logic [31:0] user, input logic [31:0] pmode,
		input logic [31:0] dmode, input logic [31:0] host_disk,
		input logic [31:0] lit_user, input logic [31:0] lit_disk,
		input logic [31:0] lit_power, input logic [31:0] led_exp);
		drive_edge();
		core_led_user  = user[0];
		core_led_power = pmode[1:0];
		core_led_disk  = dmode[1:0];
		gp_out[gp_bit_disk] = host_disk[0];
		@(negedge FPGA_CLK2_50);
		check_value("led_user", 32'(led_user), 32'(!lit_user[0]));
		check_value("led_hdd", 32'(led_hdd), 32'(!lit_disk[0]));
		check_value("led_power", 32'(led_power), 32'(!lit_power[0]));
		check_value("led", 32'(led), led_exp);
	endtask

	// Periodic syncs, checked from the fourth vertical period on
	task automatic sync_sweep(input int hh, input int hl, input int vh, input int vl,
		input logic en, input logic cs);
		int   vper;
		logic hs_n;
		logic vs_n;
		logic exp_hs;
		logic exp_vs;
		vper = vh + vl;
		check_value("cfg[csync]", 32'(cfg[cfg_bit_csync]), 32'(cs));
		for (int i = 0; i < 5 * vper; i++) begin
			drive_edge();
			vga_en  = en;
			core_hs = (i % (hh + hl)) < hh;
			core_vs = (i % vper) < vh;
			@(negedge FPGA_CLK2_50);
			if (i >= 3 * vper) begin
				// Short phase comes out high after normalising
				hs_n = (hh > hl) ? ~core_hs : core_hs;
				vs_n = (vh > vl) ? ~core_vs : core_vs;
				if (en) begin
					exp_hs = 1'b1;
					exp_vs = 1'b1;
				end else if (cs) begin
					exp_hs = ~(hs_n ^ vs_n);
					exp_vs = 1'b1;
				end else begin
					exp_hs = ~hs_n;
					exp_vs = ~vs_n;
				end
				check_value("vga_hs", 32'(vga_hs), 32'(exp_hs));
				check_value("vga_vs", 32'(vga_vs), 32'(exp_vs));
			end
		end
	endtask

	// ========================================================================
	// Main sequence
	// ========================================================================

	initial begin
		int          fd;
		int          lines;
		int          n;
		int          cyc;
		int          s0;
		int          s1;
		int          s2;
		int          s3;
		string       line;
		string       op;
		string       name;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] d;
		logic [31:0] e;
		logic [31:0] f;
		logic [31:0] g;
		logic [31:0] h;
		FPGA_CLK2_50   = 1'b0;
		resetd         = 1'b1;
		gp_out         = '0;
		btn_user       = 1'b1;
		btn_osd        = 1'b1;
		key            = 2'b11;
		core_led_user  = 1'b0;
		core_led_power = 2'b00;
		core_led_disk  = 2'b00;
		core_hs        = 1'b0;
		core_vs        = 1'b0;
		vga_en         = 1'b0;
		errors         = 0;
		checks         = 0;
		repeat (4) @(posedge FPGA_CLK2_50);
		#0.5;
		resetd = 1'b0;

		fd = $fopen("sim/board_stimulus.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("Could not open the stimulus file");
		end else begin
			lines = 0;
			// Line limit keeps a damaged file from looping forever
			while (!$feof(fd) && lines < 1000) begin
				lines++;
				line = "";
				op   = "";
				n    = $fgets(line, fd);
				if (n > 0) begin
					n = $sscanf(line, "%s", op);
				end
				if (n > 0 && op.len() > 0 && op.getc(0) != 8'h23) begin
					case (op)
						"gp": begin
							n = $sscanf(line, "%s %h %d %h %h", op, a, cyc, b, c);
							host_write(a, cyc, b, c);
						end
						"check": begin
							n = $sscanf(line, "%s %s %h", op, name, a);
							named_check(name, a);
						end
						"btn": begin
							n = $sscanf(line, "%s %h %d %h %h", op, a, cyc, b, c);
							button_step(a[0], cyc, b[0], c[0]);
						end
						"led": begin
							n = $sscanf(line, "%s %h %h %h %h %h %h %h %h", op,
								a, b, c, d, e, f, g, h);
							led_case(a, b, c, d, e, f, g, h);
						end
						"sync": begin
							n = $sscanf(line, "%s %d %d %d %d %h %h", op,
								s0, s1, s2, s3, a, b);
							sync_sweep(s0, s1, s2, s3, a[0], b[0]);
						end
						default: begin
							errors++;
							$display("Unknown op in the stimulus file: %s", op);
						end
					endcase
				end
			end
			$fclose(fd);
		end

		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule
